// File: muldiv_hilo.f
source/muldiv_pkg.sv
source/muldiv_decode.sv
source/serial_divider.sv
source/hilo_file.sv
source/muldiv_hilo.sv
verification/muldiv_hilo_sva.sv
verification/muldiv_hilo_tb.sv

// File: run_muldiv_hilo.sh
#!/bin/sh
# build with verilator, run, then look for the fail message in the log
cd "$(dirname "$0")" || exit 1
log=muldiv_hilo_sim.log
verilator --binary --timing --assert --top-module muldiv_hilo_tb \
    -f muldiv_hilo.f -o muldiv_hilo_sim > "$log" 2>&1 &&
    ./obj_dir/muldiv_hilo_sim >> "$log" 2>&1 ||
    { echo "build or run failed, see $log"; exit 1; }
grep -q "FAIL: see errors above" "$log" &&
    { echo "simulation reported failures, see $log"; exit 1; }
echo "simulation finished without failures"
exit 0

// File: verification/muldiv_hilo_tb.sv
module muldiv_hilo_tb;

    localparam int data_width  = 32;
    localparam int div_latency = data_width + 1;  // iterations plus sign fix-up
    localparam int div_timeout = 60;
    localparam int op_timeout  = 100;

    // func codes under the special opcode
    localparam logic [5:0] f_mult  = 6'h18;
    localparam logic [5:0] f_multu = 6'h19;
    localparam logic [5:0] f_div   = 6'h1a;
    localparam logic [5:0] f_divu  = 6'h1b;
    localparam logic [5:0] f_mthi  = 6'h11;
    localparam logic [5:0] f_mtlo  = 6'h13;

    logic                    clk;
    logic                    reset;
    logic                    issue;
    logic [5:0]              opcode;
    logic [5:0]              func;
    logic [data_width-1:0]   op1;
    logic [data_width-1:0]   op2;
    logic [data_width-1:0]   hi;
    logic [data_width-1:0]   lo;
    logic [2*data_width-1:0] hilo;
    logic                    busy;

    // operation handed from stimulus to the compare process
    logic                    pend_div;
    logic [2*data_width-1:0] pend_exp;
    string                   pend_what;
    int                      issued;
    int                      compared;

    integer seed;
    int     checks;
    int     errors;
    int     tests;
    int     test_errors;
    string  test_name;

    muldiv_hilo #(
        .data_width (data_width)
    ) dut (
        .clk    (clk),
        .reset  (reset),
        .issue  (issue),
        .opcode (opcode),
        .func   (func),
        .op1    (op1),
        .op2    (op2),
        .hi     (hi),
        .lo     (lo),
        .hilo   (hilo),
        .busy   (busy)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ========================================
    // reference model and checking
    // ========================================

    function automatic logic [63:0] ref_hilo(input logic [5:0] opc, input logic [5:0] f,
                                             input logic [31:0] a, input logic [31:0] b,
                                             input logic [63:0] old);
        logic signed [63:0] sa;
        logic signed [63:0] sb;
        logic signed [63:0] sq;
        logic signed [63:0] sr;
        logic [63:0]        res;
        sa  = {{32{a[31]}}, a};
        sb  = {{32{b[31]}}, b};
        res = old;  // anything not decoded leaves the pair alone
        if (opc == 6'd0 && f[4]) begin
            case (f)
                f_mult:  res = sa * sb;
                f_multu: res = {32'd0, a} * {32'd0, b};
                f_div: begin
                    if (b == 32'd0) begin
                        res = {a, 32'hffff_ffff};
                    end else begin
                        sq  = sa / sb;  // 64 bits, so min / -1 does not overflow here
                        sr  = sa % sb;
                        res = {sr[31:0], sq[31:0]};
                    end
                end
                f_divu: begin
                    if (b == 32'd0) begin
                        res = {a, 32'hffff_ffff};
                    end else begin
                        res = {a % b, a / b};
                    end
                end
                f_mthi:  res = {a, old[31:0]};
                f_mtlo:  res = {old[63:32], a};
                default: res = old;
            endcase
        end
        return res;
    endfunction

    task automatic check_value(input logic [63:0] got, input logic [63:0] exp,
                               input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: %s, got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("FAIL: see errors above");
        $finish;
    endtask

    initial begin : compare_results
        int waited;
        compared = 0;
        forever begin
            @(negedge clk);
            if (compared != issued) begin
                if (pend_div) begin
                    waited = 0;
                    while (busy && waited < div_timeout) begin
                        waited++;
                        @(negedge clk);
                    end
                end
                if (pend_div && busy) begin
                    abort_run("timeout: divider still busy long after the issue");
                end else begin
                    if (pend_div) begin
                        check_value(64'(waited), 64'(div_latency), {pend_what, " busy cycles"});
                    end
                    check_value(hilo, pend_exp, pend_what);
                    check_value({hi, lo}, pend_exp, {pend_what, " hi and lo"});
                    compared++;
                end
            end
        end
    end

    // ========================================
    // stimulus helpers
    // ========================================

    task automatic start_op(input logic [5:0] opc, input logic [5:0] f,
                            input logic [31:0] a, input logic [31:0] b, input string what);
        @(negedge clk);
        pend_exp  = ref_hilo(opc, f, a, b, hilo);
        pend_div  = (opc == 6'd0) && (f[4:3] == 2'b11) && f[1];
        pend_what = what;
        opcode    = opc;
        func      = f;
        op1       = a;
        op2       = b;
        issue     = 1'b1;
        @(posedge clk);
        issued++;       // dut sampled the issue at this edge
        @(negedge clk);
        issue = 1'b0;
    endtask

    task automatic finish_op;
        int waited;
        waited = 0;
        while (compared != issued && waited < op_timeout) begin
            waited++;
            @(posedge clk);
        end
        if (compared != issued) begin
            errors++;
            $display("timeout: result of the last operation was never compared");
        end
    endtask

    task automatic run_op(input logic [5:0] opc, input logic [5:0] f,
                          input logic [31:0] a, input logic [31:0] b, input string what);
        start_op(opc, f, a, b, what);
        finish_op();
    endtask

    task automatic start_test(input string name);
        tests++;
        test_name   = name;
        test_errors = errors;
    endtask

    task automatic report_test;
        if (errors == test_errors) begin
            $display("test %0d %s: ok", tests, test_name);
        end else begin
            $display("test %0d %s: %0d errors", tests, test_name, errors - test_errors);
        end
    endtask

    // ========================================
    // test sequence
    // ========================================

    initial begin : stimulus
        logic [31:0] a;
        logic [31:0] b;
        logic [63:0] held;
        seed      = 8;
        checks    = 0;
        errors    = 0;
        tests     = 0;
        issued    = 0;
        pend_div  = 1'b0;
        pend_exp  = '0;
        pend_what = "";
        reset     = 1'b1;
        issue     = 1'b0;
        opcode    = 6'd0;
        func      = 6'd0;
        op1       = '0;
        op2       = '0;
        repeat (5) @(negedge clk);
        reset = 1'b0;

        start_test("reset values");
        @(negedge clk);
        check_value(hilo, 64'd0, "hilo after reset");
        check_value(64'(busy), 64'd0, "busy after reset");
        report_test();

        start_test("mthi and mtlo");
        for (int i = 0; i < 8; i++) begin
            a = $random(seed);
            b = $random(seed);
            run_op(6'd0, i[0] ? f_mtlo : f_mthi, a, b, i[0] ? "mtlo" : "mthi");
        end
        report_test();

        start_test("mult and multu");
        for (int i = 0; i < 40; i++) begin
            a = $random(seed);
            b = $random(seed);
            run_op(6'd0, f_mult, a, b, "mult");
            run_op(6'd0, f_multu, a, b, "multu");
        end
        report_test();

        start_test("div and divu");
        for (int i = 0; i < 40; i++) begin
            a = $random(seed);
            b = $random(seed);
            b = $signed(b) >>> ($unsigned($random(seed)) % 28);  // smaller divisors too
            run_op(6'd0, i[0] ? f_divu : f_div, a, b, i[0] ? "divu" : "div");
        end
        report_test();

        start_test("divide corner cases");
        a = $random(seed);
        run_op(6'd0, f_div, a, 32'd0, "div by zero");
        run_op(6'd0, f_divu, a, 32'd0, "divu by zero");
        run_op(6'd0, f_div, 32'h8000_0000, 32'hffff_ffff, "div overflow");
        run_op(6'd0, f_divu, 32'h8000_0000, 32'hffff_ffff, "divu min by all ones");
        report_test();

        start_test("dropped issues");
        a = $random(seed);
        b = $random(seed);
        start_op(6'd0, f_div, a, b | 32'd1, "div before busy issue");
        @(negedge clk);
        held   = hilo;
        opcode = 6'd0;
        func   = f_mult;
        op1    = $random(seed);
        op2    = $random(seed);
        issue  = 1'b1;  // divider is busy, so the decoder must drop this
        @(negedge clk);
        issue = 1'b0;
        check_value(hilo, held, "mult issued while busy");
        finish_op();
        run_op(6'h1c, f_mult, a, b, "nonzero opcode");
        run_op(6'd0, 6'h08, a, b, "func bit 4 clear");  // mult with bit 4 cleared
        report_test();

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// File: verification/muldiv_hilo_sva.sv
module muldiv_hilo_sva #(
    parameter int data_width = 32
) (
    input logic                  clk,
    input logic                  reset,
    input logic                  busy,
    input logic                  done,
    input logic [data_width-1:0] hi,
    input logic [data_width-1:0] lo
);

    // ========================================
    // reset values
    // ========================================

    reset_clears: assert property (@(posedge clk)
        reset |=> (hi == '0) && (lo == '0) && !busy && !done)
        else $error("hi, lo, busy or done not cleared by reset");

    // ========================================
    // divider end of run
    // ========================================

    done_one_cycle: assert property (@(posedge clk) disable iff (reset)
        done |=> !done)
        else $error("divider done lasted more than one cycle");

    busy_falls_on_done: assert property (@(posedge clk) disable iff (reset)
        done |=> !busy)  // busy drops at the same edge that writes hi/lo
        else $error("busy still high after divider done");

endmodule

bind muldiv_hilo muldiv_hilo_sva #(.data_width(data_width)) u_sva (
    .clk   (clk),
    .reset (reset),
    .busy  (busy),
    .done  (div_done),
    .hi    (hi),
    .lo    (lo)
);

// File: source/muldiv_hilo.sv
module muldiv_hilo #(
    parameter int data_width = 32
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    issue,
    input  logic [5:0]              opcode,
    input  logic [5:0]              func,
    input  logic [data_width-1:0]   op1,
    input  logic [data_width-1:0]   op2,
    output logic [data_width-1:0]   hi,
    output logic [data_width-1:0]   lo,
    output logic [2*data_width-1:0] hilo,
    output logic                    busy
);
    import muldiv_pkg::*;

    muldiv_cmd_t           cmd;
    logic                  div_start;
    logic                  div_done;
    logic [data_width-1:0] quotient;
    logic [data_width-1:0] remainder;

    // ========================================
    // decode, busy drops new issues here
    // ========================================

    muldiv_decode u_decode (
        .opcode (opcode),
        .func   (func),
        .op1    (op1),
        .op2    (op2),
        .issue  (issue),
        .busy   (busy),
        .cmd    (cmd)
    );

    assign div_start = cmd.is_div;

    serial_divider #(
        .data_width (data_width)
    ) u_divider (
        .clk       (clk),
        .reset     (reset),
        .start     (div_start),
        .is_signed (cmd.is_signed),
        .dividend  (cmd.a[data_width-1:0]),
        .divisor   (cmd.b[data_width-1:0]),
        .busy      (busy),
        .done      (div_done),
        .quotient  (quotient),
        .remainder (remainder)
    );

    hilo_file #(
        .data_width (data_width)
    ) u_hilo (
        .clk       (clk),
        .reset     (reset),
        .cmd       (cmd),
        .div_done  (div_done),
        .quotient  (quotient),
        .remainder (remainder),
        .hi        (hi),
        .lo        (lo)
    );

    assign hilo = {hi, lo};

endmodule

// File: source/hilo_file.sv
module hilo_file #(
    parameter int data_width = 32
) (
    input  logic                    clk,
    input  logic                    reset,
    input  muldiv_pkg::muldiv_cmd_t cmd,
    input  logic                    div_done,
    input  logic [data_width-1:0]   quotient,
    input  logic [data_width-1:0]   remainder,
    output logic [data_width-1:0]   hi,
    output logic [data_width-1:0]   lo
);
    import muldiv_pkg::*;

    logic [data_width-1:0]          a_val;
    logic [data_width-1:0]          b_val;
    logic signed [2*data_width-1:0] prod_s;
    logic [2*data_width-1:0]        prod_u;
    logic [2*data_width-1:0]        prod;

    assign a_val = cmd.a[data_width-1:0];
    assign b_val = cmd.b[data_width-1:0];

    // ========================================
    // single-cycle multipliers
    // ========================================

    assign prod_s = (2*data_width)'($signed(a_val)) * (2*data_width)'($signed(b_val));
    assign prod_u = (2*data_width)'(a_val) * (2*data_width)'(b_val);
    assign prod   = cmd.is_signed ? prod_s : prod_u;

    // ========================================
    // hi/lo registers
    // ========================================

    always_ff @(posedge clk) begin
        if (reset) begin
            hi <= '0;
            lo <= '0;
        end else if (div_done) begin
            // decoder holds off new commands while the divider runs
            hi <= remainder;
            lo <= quotient;
        end else begin
            unique case (cmd.op)
                op_mult, op_multu: begin
                    hi <= prod[2*data_width-1:data_width];
                    lo <= prod[data_width-1:0];
                end
                op_mthi: hi <= a_val;
                op_mtlo: lo <= a_val;
                default: ;  // none, or divide waiting for done
            endcase
        end
    end

endmodule

// File: source/serial_divider.sv
module serial_divider #(
    parameter int data_width = 32
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  start,
    input  logic                  is_signed,
    input  logic [data_width-1:0] dividend,
    input  logic [data_width-1:0] divisor,
    output logic                  busy,
    output logic                  done,
    output logic [data_width-1:0] quotient,
    output logic [data_width-1:0] remainder
);

    localparam int count_width = $clog2(data_width + 1);

    logic [count_width-1:0] count;     // iterations done so far
    logic                   fixup;     // last cycle, signs applied

    logic [data_width-1:0]  quo;       // dividend shifts out, quotient shifts in
    logic [data_width-1:0]  rem;       // partial remainder
    logic [data_width-1:0]  div_mag;   // divisor magnitude
    logic                   q_neg;
    logic                   r_neg;

    logic                   dvd_neg;
    logic                   dvs_neg;
    logic [data_width-1:0]  dvd_abs;
    logic [data_width-1:0]  dvs_abs;

    logic [data_width:0]    shifted;
    logic [data_width:0]    trial;

    // ========================================
    // operand magnitudes at start
    // ========================================

    assign dvd_neg = is_signed && dividend[data_width-1];
    assign dvs_neg = is_signed && divisor[data_width-1];
    assign dvd_abs = dvd_neg ? -dividend : dividend;
    assign dvs_abs = dvs_neg ? -divisor : divisor;

    // ========================================
    // one restoring step
    // ========================================

    assign shifted = {rem, quo[data_width-1]};
    assign trial   = shifted - {1'b0, div_mag};

    // ========================================
    // control
    // ========================================

    always_ff @(posedge clk) begin
        if (reset) begin
            busy  <= 1'b0;
            count <= '0;
        end else if (!busy) begin
            if (start) begin
                busy  <= 1'b1;
                count <= '0;
            end
        end else if (fixup) begin
            busy <= 1'b0;  // results taken at this edge
        end else begin
            count <= count + count_width'(1);
        end
    end

    assign fixup = busy && (count == count_width'(data_width));
    assign done  = fixup;

    // ========================================
    // datapath
    // ========================================

    always_ff @(posedge clk) begin
        if (!busy && start) begin
            quo     <= dvd_abs;
            rem     <= '0;
            div_mag <= dvs_abs;
            // a zero divisor keeps the all-ones quotient unsigned
            q_neg   <= (dvd_neg != dvs_neg) && (divisor != '0);
            r_neg   <= dvd_neg;
        end else if (busy && !fixup) begin
            if (!trial[data_width]) begin
                rem <= trial[data_width-1:0];
                quo <= {quo[data_width-2:0], 1'b1};
            end else begin
                rem <= shifted[data_width-1:0];
                quo <= {quo[data_width-2:0], 1'b0};
            end
        end
    end

    // sign fix-up, sampled by the hi/lo file on done
    assign quotient  = q_neg ? -quo : quo;
    assign remainder = r_neg ? -rem : rem;

endmodule

// File: source/muldiv_decode.sv
module muldiv_decode (
    input  logic [5:0]                           opcode,
    input  logic [5:0]                           func,
    input  logic [muldiv_pkg::cmd_data_width-1:0] op1,
    input  logic [muldiv_pkg::cmd_data_width-1:0] op2,
    input  logic                                 issue,
    input  logic                                 busy,
    output muldiv_pkg::muldiv_cmd_t              cmd
);
    import muldiv_pkg::*;

    logic       in_group;
    logic [1:0] group;
    logic [1:0] sel;

    assign in_group = issue && !busy && (opcode == opcode_special) && func[func_group_bit];
    assign group    = func[4:3];
    assign sel      = func[1:0];

    always_comb begin
        cmd           = '0;
        cmd.op        = op_none;
        cmd.a         = op1;  // operands pass through untouched
        cmd.b         = op2;

        if (in_group) begin
            if (group == func_arith_group) begin
                // func[1] picks divide, func[0] picks unsigned
                unique case (sel)
                    2'd0:    cmd.op = op_mult;
                    2'd1:    cmd.op = op_multu;
                    2'd2:    cmd.op = op_div;
                    default: cmd.op = op_divu;
                endcase
                cmd.is_signed = !sel[0];
                cmd.is_div    = sel[1];
            end else if (group == func_move_group) begin
                if (sel == func_move_hi) begin
                    cmd.op = op_mthi;
                end else if (sel == func_move_lo) begin
                    cmd.op = op_mtlo;
                end
            end
        end
    end

endmodule

// File: source/muldiv_pkg.sv
package muldiv_pkg;

    // ========================================
    // command word
    // ========================================

    localparam int cmd_data_width = 32;  // operand width carried in the command

    typedef enum logic [2:0] {
        op_none  = 3'd0,
        op_mult  = 3'd1,
        op_multu = 3'd2,
        op_div   = 3'd3,
        op_divu  = 3'd4,
        op_mthi  = 3'd5,
        op_mtlo  = 3'd6
    } muldiv_op_e;

    typedef struct packed {
        muldiv_op_e                op;
        logic                      is_signed;  // mult or div, signed flavour
        logic                      is_div;     // starts the serial divider
        logic [cmd_data_width-1:0] a;          // rs operand
        logic [cmd_data_width-1:0] b;          // rt operand
    } muldiv_cmd_t;

    // ========================================
    // instruction encoding
    // ========================================

    // all hi/lo writers sit under the special opcode
    localparam logic [5:0] opcode_special = 6'd0;

    // func bit that marks the hi/lo group
    localparam int func_group_bit = 4;

    // func[4:3] values inside the group
    localparam logic [1:0] func_arith_group = 2'd3;  // mult, multu, div, divu
    localparam logic [1:0] func_move_group  = 2'd2;  // mthi, mtlo

    // func[1:0] values inside the move group
    localparam logic [1:0] func_move_hi = 2'd1;
    localparam logic [1:0] func_move_lo = 2'd3;

endpackage
